/* hw/edgePkg.sv */
`default_nettype none

package edgePkg;

    localparam logic [7:0] edgeCiId = 8'h2A;     // custom instruction id of the accelerator.
    localparam int frameSize = 16;               // pixels per frame side.
    localparam int frameWords = 64;              // four pixels per 32-bit word.
    localparam int wordAddrWidth = 6;
    localparam int pixelWidth = 8;
    localparam int magnitudeWidth = 11;          // |Gx| + |Gy| never exceeds 2040.
    localparam logic [7:0] edgeOn = 8'hFF;
    localparam logic [7:0] edgeOff = 8'h00;

    // Opcode travels in valueB bits 1..0.
    typedef enum logic [1:0] {
        opWritePixels  = 2'd0,
        opSetThreshold = 2'd1,
        opDetect       = 2'd2,
        opNone         = 2'd3
    } ciOpcode;

    typedef enum logic [1:0] {
        frontIdle = 2'd0,
        frontBusy = 2'd1
    } frontState;

    typedef enum logic [1:0] {
        windowIdle    = 2'd0,
        windowFetch   = 2'd1,
        windowCompute = 2'd2,
        windowReply   = 2'd3
    } windowState;

endpackage

`default_nettype wire

/* hw/ciBus.sv */
`timescale 1ns/10ps
`default_nettype none

interface ciBus;

    logic              start;      // one-cycle pulse per routed instruction.
    edgePkg::ciOpcode  opcode;
    logic [31:0]       valueA;
    logic [31:0]       valueB;
    logic              done;       // exactly one pulse per start, at least one cycle later.
    logic [31:0]       result;

    modport front (
        output start, opcode, valueA, valueB,
        input  done, result
    );

    modport unit (
        input  start, opcode, valueA, valueB,
        output done, result
    );

endinterface

`default_nettype wire

/* hw/memPort.sv */
`timescale 1ns/10ps
`default_nettype none

interface memPort;

    logic                                request;    // held with its fields until grant.
    logic                                write;
    logic [edgePkg::wordAddrWidth-1:0]   address;
    logic [31:0]                         writeData;
    logic                                grant;
    logic [31:0]                         readData;   // valid the cycle after a granted read.

    modport peer (
        output request, write, address, writeData,
        input  grant, readData
    );

    modport store (
        input  request, write, address, writeData,
        output grant, readData
    );

endinterface

`default_nettype wire

/* hw/ciFrontEnd.sv */
`timescale 1ns/10ps
`default_nettype none

module ciFrontEnd (
    input  logic        clock,
    input  logic        reset,
    input  logic        start,
    input  logic [7:0]  ciN,
    input  logic [31:0] valueA,
    input  logic [31:0] valueB,
    output logic        done,
    output logic [31:0] result,
    ciBus.front         writerBus,
    ciBus.front         windowBus
);

    edgePkg::frontState state;
    edgePkg::ciOpcode   opcode;
    edgePkg::ciOpcode   opcodeReg;
    logic               accept;
    logic               writerStart;
    logic               windowStart;
    logic               noneDone;
    logic               peerDone;
    logic [31:0]        valueAReg;
    logic [31:0]        valueBReg;

    assign opcode   = edgePkg::ciOpcode'(valueB[1:0]);
    assign accept   = start && (ciN == edgePkg::edgeCiId);   // foreign ids are ignored.
    assign peerDone = writerBus.done || windowBus.done;

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= edgePkg::frontIdle;
            writerStart <= 1'b0;
            windowStart <= 1'b0;
            noneDone    <= 1'b0;
        end else begin
            writerStart <= accept && (opcode == edgePkg::opWritePixels);
            windowStart <= accept && (opcode == edgePkg::opSetThreshold ||
                                      opcode == edgePkg::opDetect);
            noneDone    <= accept && (opcode == edgePkg::opNone);   // answered locally.
            case (state)
                edgePkg::frontIdle: if (accept && opcode != edgePkg::opNone) state <= edgePkg::frontBusy;
                default:            if (peerDone) state <= edgePkg::frontIdle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            opcodeReg <= opcode;
            valueAReg <= valueA;
            valueBReg <= valueB;
        end
    end

    assign writerBus.start  = writerStart;
    assign writerBus.opcode = opcodeReg;
    assign writerBus.valueA = valueAReg;
    assign writerBus.valueB = valueBReg;
    assign windowBus.start  = windowStart;
    assign windowBus.opcode = opcodeReg;
    assign windowBus.valueA = valueAReg;
    assign windowBus.valueB = valueBReg;

    // The peer done is already a registered pulse, so it is passed straight to the processor.
    assign done   = noneDone || (state == edgePkg::frontBusy && peerDone);
    assign result = (state != edgePkg::frontBusy) ? 32'd0 :
                    windowBus.done ? windowBus.result : writerBus.result;

    // The processor must wait for done before issuing the next instruction.
    assert property (@(posedge clock) disable iff (reset)
        (start && ciN == edgePkg::edgeCiId) |-> (state == edgePkg::frontIdle));

endmodule

`default_nettype wire

/* hw/pixelWriter.sv */
`timescale 1ns/10ps
`default_nettype none

module pixelWriter (
    input  logic clock,
    input  logic reset,
    ciBus.unit   cmd,
    memPort.peer mem
);

    logic                              request;
    logic                              done;
    logic [edgePkg::wordAddrWidth-1:0] address;
    logic [31:0]                       word;

    always_ff @(posedge clock) begin
        if (reset) begin
            request <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (cmd.start) begin
                request <= 1'b1;
            end else if (request && mem.grant) begin
                request <= 1'b0;   // the write lands on this same edge.
                done    <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (cmd.start) begin
            address <= cmd.valueB[8 +: edgePkg::wordAddrWidth];   // row times 4 plus column group.
            word    <= cmd.valueA;
        end
    end

    assign mem.request   = request;
    assign mem.write     = 1'b1;
    assign mem.address   = address;
    assign mem.writeData = word;
    assign cmd.done      = done;
    assign cmd.result    = 32'd0;

    // A waiting request must not change under the arbiter.
    assert property (@(posedge clock) disable iff (reset)
        (mem.request && !mem.grant) |=>
            (mem.request && $stable(mem.address) && $stable(mem.writeData)));

endmodule

`default_nettype wire

/* hw/sobelKernel.sv */
`timescale 1ns/10ps
`default_nettype none

module sobelKernel (
    input  logic                                      clock,
    input  logic [8:0][edgePkg::pixelWidth-1:0]       window,
    input  logic [edgePkg::pixelWidth-1:0]            threshold,
    output logic [edgePkg::magnitudeWidth-1:0]        magnitude,
    output logic [7:0]                                edgeFlag
);

    // Window index is row * 3 + column, row 0 on top.
    logic [9:0]                           gxPos;
    logic [9:0]                           gxNeg;
    logic [9:0]                           gyPos;
    logic [9:0]                           gyNeg;
    logic [9:0]                           gxAbs;
    logic [9:0]                           gyAbs;
    logic [edgePkg::magnitudeWidth-1:0]   sum;

    assign gxPos = {2'b00, window[2]} + {1'b0, window[5], 1'b0} + {2'b00, window[8]};
    assign gxNeg = {2'b00, window[0]} + {1'b0, window[3], 1'b0} + {2'b00, window[6]};
    assign gyPos = {2'b00, window[6]} + {1'b0, window[7], 1'b0} + {2'b00, window[8]};
    assign gyNeg = {2'b00, window[0]} + {1'b0, window[1], 1'b0} + {2'b00, window[2]};

    // Each side peaks at 1020, so the differences are taken unsigned.
    assign gxAbs = (gxPos > gxNeg) ? gxPos - gxNeg : gxNeg - gxPos;
    assign gyAbs = (gyPos > gyNeg) ? gyPos - gyNeg : gyNeg - gyPos;
    assign sum   = {1'b0, gxAbs} + {1'b0, gyAbs};

    always_ff @(posedge clock) begin
        magnitude <= sum;
        edgeFlag  <= (sum > {3'b000, threshold}) ? edgePkg::edgeOn : edgePkg::edgeOff;
    end

endmodule

`default_nettype wire

/* hw/windowEngine.sv */
`timescale 1ns/10ps
`default_nettype none

module windowEngine (
    input  logic clock,
    input  logic reset,
    ciBus.unit   cmd,
    memPort.peer mem
);

    edgePkg::windowState                         state;
    logic [edgePkg::pixelWidth-1:0]              threshold;
    logic [8:0][edgePkg::pixelWidth-1:0]         window;
    logic [edgePkg::magnitudeWidth-1:0]          magnitude;
    logic [7:0]                                  edgeFlag;
    logic [3:0]                                  centreX;
    logic [3:0]                                  centreY;
    logic [3:0]                                  pixelX;
    logic [3:0]                                  pixelY;
    logic [3:0]                                  tapIndex;
    logic [1:0]                                  tapCol;
    logic [1:0]                                  tapRow;
    logic                                        request;
    logic                                        pending;
    logic                                        done;
    logic [31:0]                                 result;
    logic                                        startThreshold;
    logic                                        startDetect;
    logic                                        captureTap;
    logic                                        lastTap;

    assign startThreshold = cmd.start && cmd.opcode == edgePkg::opSetThreshold &&
                            state == edgePkg::windowIdle;
    assign startDetect    = cmd.start && cmd.opcode == edgePkg::opDetect &&
                            state == edgePkg::windowIdle;
    assign captureTap     = (state == edgePkg::windowFetch) && pending;
    assign lastTap        = (tapIndex == 4'd8);

    // Neighbour coordinate of the current tap, offset -1..+1 around the centre.
    assign pixelX = centreX + {2'b00, tapCol} - 4'd1;
    assign pixelY = centreY + {2'b00, tapRow} - 4'd1;

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= edgePkg::windowIdle;
            request   <= 1'b0;
            pending   <= 1'b0;
            done      <= 1'b0;
            threshold <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                edgePkg::windowIdle: begin
                    if (startThreshold) begin
                        threshold <= cmd.valueA[7:0];
                        done      <= 1'b1;
                    end else if (startDetect) begin
                        request <= 1'b1;
                        state   <= edgePkg::windowFetch;
                    end
                end
                edgePkg::windowFetch: begin
                    if (pending) begin
                        pending <= 1'b0;
                        if (lastTap) state <= edgePkg::windowCompute;
                        else request <= 1'b1;   // next neighbour.
                    end else if (mem.grant) begin
                        request <= 1'b0;
                        pending <= 1'b1;        // readData arrives next cycle.
                    end
                end
                edgePkg::windowCompute: state <= edgePkg::windowReply;   // kernel register.
                default: begin
                    done  <= 1'b1;
                    state <= edgePkg::windowIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (startDetect) begin
            centreX  <= cmd.valueA[3:0];
            centreY  <= cmd.valueA[7:4];
            tapIndex <= 4'd0;
            tapCol   <= 2'd0;
            tapRow   <= 2'd0;
        end
        if (captureTap) begin
            window[tapIndex] <= mem.readData[pixelX[1:0]*8 +: 8];   // lowest byte is lowest x.
            if (!lastTap) begin
                tapIndex <= tapIndex + 4'd1;
                if (tapCol == 2'd2) begin
                    tapCol <= 2'd0;
                    tapRow <= tapRow + 2'd1;
                end else begin
                    tapCol <= tapCol + 2'd1;
                end
            end
        end
        if (state == edgePkg::windowReply) result <= {13'd0, magnitude, edgeFlag};
        else if (startThreshold) result <= 32'd0;
    end

    sobelKernel sobelKernel_inst (
        .clock     (clock),
        .window    (window),
        .threshold (threshold),
        .magnitude (magnitude),
        .edgeFlag  (edgeFlag)
    );

    assign mem.request   = request;
    assign mem.write     = 1'b0;
    assign mem.address   = {pixelY, pixelX[3:2]};   // y times 4 plus x over 4.
    assign mem.writeData = 32'd0;
    assign cmd.done      = done;
    assign cmd.result    = result;

    // Border pixels have no full neighbourhood in the frame.
    assert property (@(posedge clock) disable iff (reset)
        (cmd.start && cmd.opcode == edgePkg::opDetect) |->
            (cmd.valueA[3:0] >= 4'd1 && cmd.valueA[3:0] <= edgePkg::frameSize - 2 &&
             cmd.valueA[7:4] >= 4'd1 && cmd.valueA[7:4] <= edgePkg::frameSize - 2));

endmodule

`default_nettype wire

/* hw/sharedFrameStore.sv */
`timescale 1ns/10ps
`default_nettype none

module sharedFrameStore (
    input  logic  clock,
    input  logic  reset,
    memPort.store writerPort,
    memPort.store windowPort
);

    logic [31:0]                       frame [0:edgePkg::frameWords-1];
    logic                              lastWindow;   // the previous grant went to the window engine.
    logic                              writerGrant;
    logic                              windowGrant;
    logic                              anyGrant;
    logic                              selWrite;
    logic [edgePkg::wordAddrWidth-1:0] selAddress;
    logic [31:0]                       selData;
    logic [31:0]                       readData;

    // Under contention the side that was not served last wins.
    assign writerGrant = writerPort.request && (!windowPort.request || lastWindow);
    assign windowGrant = windowPort.request && (!writerPort.request || !lastWindow);
    assign anyGrant    = writerGrant || windowGrant;

    assign selWrite   = writerGrant ? writerPort.write     : windowPort.write;
    assign selAddress = writerGrant ? writerPort.address   : windowPort.address;
    assign selData    = writerGrant ? writerPort.writeData : windowPort.writeData;

    always_ff @(posedge clock) begin
        if (reset) begin
            lastWindow <= 1'b0;
        end else if (anyGrant) begin
            lastWindow <= windowGrant;
        end
    end

    always_ff @(posedge clock) begin
        if (anyGrant && selWrite) begin
            frame[selAddress] <= selData;
        end
        readData <= frame[selAddress];   // only meaningful after a granted read.
    end

    assign writerPort.grant    = writerGrant;
    assign windowPort.grant    = windowGrant;
    assign writerPort.readData = readData;
    assign windowPort.readData = readData;

    // A peer that loses under contention is served on the very next cycle.
    assert property (@(posedge clock) disable iff (reset)
        (writerPort.request && !writerPort.grant) |=> writerPort.grant);
    assert property (@(posedge clock) disable iff (reset)
        (windowPort.request && !windowPort.grant) |=> windowPort.grant);

endmodule

`default_nettype wire

/* hw/edgeAccelerator.sv */
`timescale 1ns/10ps
`default_nettype none

module edgeAccelerator (
    input  logic        clock,
    input  logic        reset,
    input  logic        start,
    input  logic [7:0]  ciN,
    input  logic [31:0] valueA,
    input  logic [31:0] valueB,
    output logic        done,
    output logic [31:0] result
);

    ciBus   writerBus ();
    ciBus   windowBus ();
    memPort writerMem ();
    memPort windowMem ();

    ciFrontEnd ciFrontEnd_inst (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .ciN       (ciN),
        .valueA    (valueA),
        .valueB    (valueB),
        .done      (done),
        .result    (result),
        .writerBus (writerBus.front),
        .windowBus (windowBus.front)
    );

    pixelWriter pixelWriter_inst (
        .clock (clock),
        .reset (reset),
        .cmd   (writerBus.unit),
        .mem   (writerMem.peer)
    );

    windowEngine windowEngine_inst (
        .clock (clock),
        .reset (reset),
        .cmd   (windowBus.unit),
        .mem   (windowMem.peer)
    );

    sharedFrameStore sharedFrameStore_inst (
        .clock      (clock),
        .reset      (reset),
        .writerPort (writerMem.store),
        .windowPort (windowMem.store)
    );

endmodule

`default_nettype wire

/* verification/edgeAcceleratorTb.sv */
`timescale 1ns/10ps
`default_nettype none

module edgeAcceleratorTb;

    typedef struct packed {
        logic        isDetect;
        logic [31:0] value;
    } expectEntry;

    logic        clock;
    logic        reset;
    logic        start;
    logic [7:0]  ciN;
    logic [31:0] valueA;
    logic [31:0] valueB;
    logic        done;
    logic [31:0] result;

    logic [7:0]  shadowFrame [0:15][0:15];   // indexed [y][x].
    logic [7:0]  shadowThreshold;
    expectEntry  expected [$];                // one entry per instruction that must answer.
    expectEntry  checkedEntry;
    int          seed;

    edgeAccelerator edgeAccelerator_inst (
        .clock  (clock),
        .reset  (reset),
        .start  (start),
        .ciN    (ciN),
        .valueA (valueA),
        .valueB (valueB),
        .done   (done),
        .result (result)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Sobel gradients with the left column and top row taken as negative.
    function automatic void sobelReference(input logic [7:0] frame [0:15][0:15],
                                           input int x, input int y,
                                           input logic [7:0] threshold,
                                           output logic [10:0] magnitude,
                                           output logic [7:0] flag);
        int left;
        int right;
        int top;
        int bottom;
        int sum;
        left   = int'(frame[y-1][x-1]) + 2 * int'(frame[y][x-1]) + int'(frame[y+1][x-1]);
        right  = int'(frame[y-1][x+1]) + 2 * int'(frame[y][x+1]) + int'(frame[y+1][x+1]);
        top    = int'(frame[y-1][x-1]) + 2 * int'(frame[y-1][x]) + int'(frame[y-1][x+1]);
        bottom = int'(frame[y+1][x-1]) + 2 * int'(frame[y+1][x]) + int'(frame[y+1][x+1]);
        sum = ((right > left) ? right - left : left - right) +
              ((bottom > top) ? bottom - top : top - bottom);
        magnitude = 11'(sum);
        flag = (sum > int'(threshold)) ? edgePkg::edgeOn : edgePkg::edgeOff;
    endfunction

    function automatic logic [31:0] packOperandB(input edgePkg::ciOpcode op,
                                                 input logic [5:0] address);
        return {18'd0, address, 6'd0, op};
    endfunction

    task automatic checkResult(input logic [31:0] expectedValue, input logic [31:0] actual);
        if (actual !== expectedValue) begin
            $display("Fail at %0t: result expected %h, got %h", $time, expectedValue, actual);
            $display("Test failed");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic checkMagnitude(input logic [edgePkg::magnitudeWidth-1:0] expectedValue,
                                  input logic [edgePkg::magnitudeWidth-1:0] actual);
        if (actual !== expectedValue) begin
            $display("Fail at %0t: magnitude expected %0d, got %0d", $time, expectedValue, actual);
            $display("Test failed");
            $fatal(1, "magnitude mismatch");
        end
    endtask

    task automatic checkFlag(input logic [7:0] expectedValue, input logic [7:0] actual);
        if (actual !== expectedValue) begin
            $display("Fail at %0t: edge flag expected %h, got %h", $time, expectedValue, actual);
            $display("Test failed");
            $fatal(1, "edge flag mismatch");
        end
    endtask

    task automatic checkLatency(input int minimum, input int maximum, input int actual);
        if (actual < minimum || actual > maximum) begin
            $display("Fail at %0t: latency expected %0d to %0d cycles, got %0d",
                     $time, minimum, maximum, actual);
            $display("Test failed");
            $fatal(1, "latency mismatch");
        end
    endtask

    // Every done is matched against the oldest outstanding expectation.
    always @(negedge clock) begin
        if (!reset && done) begin
            if (expected.size() == 0) begin
                $display("The DUT raised done at %0t with no instruction outstanding.", $time);
                $display("Test failed");
                $fatal(1, "unexpected done");
            end
            checkedEntry = expected.pop_front();
            if (checkedEntry.isDetect) begin
                checkMagnitude(checkedEntry.value[18:8], result[18:8]);
                checkFlag(checkedEntry.value[7:0], result[7:0]);
            end
            checkResult(checkedEntry.value, result);
        end
    end

    // Returns the number of cycles from the start cycle to the done cycle.
    task automatic issueInstruction(input logic [7:0] id, input logic [31:0] a,
                                    input logic [31:0] b, output int latency);
        @(posedge clock);
        #1;
        start  = 1'b1;
        ciN    = id;
        valueA = a;
        valueB = b;
        @(posedge clock);
        #1;
        start   = 1'b0;
        latency = 1;
        @(negedge clock);
        while (!done && latency < 100) begin
            @(negedge clock);
            latency = latency + 1;
        end
        if (!done) begin
            $display("No done arrived within 100 cycles of a start at %0t.", $time);
            $display("Test failed");
            $fatal(1, "instruction timeout");
        end
    endtask

    task automatic setThreshold(input logic [7:0] threshold);
        int latency;
        expected.push_back('{1'b0, 32'd0});
        issueInstruction(edgePkg::edgeCiId, {24'd0, threshold},
                         packOperandB(edgePkg::opSetThreshold, 6'd0), latency);
        checkLatency(2, 2, latency);
        shadowThreshold = threshold;
    endtask

    task automatic writeFrame();
        int latency;
        int y;
        int x;
        for (int address = 0; address < edgePkg::frameWords; address++) begin
            y = address / 4;
            x = (address % 4) * 4;
            expected.push_back('{1'b0, 32'd0});
            issueInstruction(edgePkg::edgeCiId,
                             {shadowFrame[y][x+3], shadowFrame[y][x+2],
                              shadowFrame[y][x+1], shadowFrame[y][x]},
                             packOperandB(edgePkg::opWritePixels, 6'(address)), latency);
            checkLatency(3, 99, latency);
        end
    endtask

    task automatic detectPixel(input int x, input int y, input logic [31:0] expectedValue);
        int latency;
        expected.push_back('{1'b1, expectedValue});
        issueInstruction(edgePkg::edgeCiId, {24'd0, 4'(y), 4'(x)},
                         packOperandB(edgePkg::opDetect, 6'd0), latency);
    endtask

    task automatic detectAgainstReference();
        logic [10:0] magnitude;
        logic [7:0]  flag;
        for (int y = 1; y < edgePkg::frameSize - 1; y++) begin
            for (int x = 1; x < edgePkg::frameSize - 1; x++) begin
                sobelReference(shadowFrame, x, y, shadowThreshold, magnitude, flag);
                detectPixel(x, y, {13'd0, magnitude, flag});
            end
        end
    endtask

    task automatic foreignIdIgnored();
        int waited;
        @(posedge clock);
        #1;
        start  = 1'b1;
        ciN    = edgePkg::edgeCiId ^ 8'h81;   // any other id.
        valueA = 32'h0000_0077;
        valueB = packOperandB(edgePkg::opSetThreshold, 6'd0);
        @(posedge clock);
        #1;
        start  = 1'b0;
        waited = 0;
        while (waited < 20) begin
            @(negedge clock);
            if (done) begin
                $display("A start with a foreign instruction id produced done at %0t.", $time);
                $display("Test failed");
                $fatal(1, "foreign id answered");
            end
            waited = waited + 1;
        end
    endtask

    initial begin
        int latency;
        start           = 1'b0;
        ciN             = 8'd0;
        valueA          = 32'd0;
        valueB          = 32'd0;
        reset           = 1'b1;
        seed            = 32'hb5ed;
        shadowThreshold = 8'd0;
        repeat (4) @(posedge clock);
        #1 reset = 1'b0;

        setThreshold(8'd40);
        expected.push_back('{1'b0, 32'd0});   // the reserved opcode answers with zero.
        issueInstruction(edgePkg::edgeCiId, 32'hFFFF_FFFF,
                         packOperandB(edgePkg::opNone, 6'd0), latency);
        checkLatency(1, 1, latency);
        foreignIdIgnored();

        for (int y = 0; y < edgePkg::frameSize; y++)
            for (int x = 0; x < edgePkg::frameSize; x++)
                shadowFrame[y][x] = 8'($random(seed));
        writeFrame();
        setThreshold(8'd0);
        detectAgainstReference();
        setThreshold(8'd128);
        detectAgainstReference();
        setThreshold(8'd255);
        detectAgainstReference();

        // A flat frame has no gradient anywhere.
        for (int y = 0; y < edgePkg::frameSize; y++)
            for (int x = 0; x < edgePkg::frameSize; x++)
                shadowFrame[y][x] = 8'h5A;
        writeFrame();
        setThreshold(8'd0);
        for (int y = 1; y < edgePkg::frameSize - 1; y++)
            for (int x = 1; x < edgePkg::frameSize - 1; x++)
                detectPixel(x, y, {13'd0, 11'd0, edgePkg::edgeOff});

        // Vertical step between columns 7 and 8 gives 4 times 255 on both sides of it.
        for (int y = 0; y < edgePkg::frameSize; y++)
            for (int x = 0; x < edgePkg::frameSize; x++)
                shadowFrame[y][x] = (x < 8) ? 8'h00 : 8'hFF;
        writeFrame();
        setThreshold(8'd200);
        for (int y = 1; y < edgePkg::frameSize - 1; y++)
            for (int x = 7; x <= 8; x++)
                detectPixel(x, y, {13'd0, 11'd1020, edgePkg::edgeOn});

        @(posedge clock);
        if (expected.size() != 0) begin
            $display("%0d expected answers never arrived.", expected.size());
            $display("Test failed");
            $fatal(1, "missing answers");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/edgePkg.sv
hw/ciBus.sv
hw/memPort.sv
hw/ciFrontEnd.sv
hw/pixelWriter.sv
hw/sobelKernel.sv
hw/windowEngine.sv
hw/sharedFrameStore.sv
hw/edgeAccelerator.sv
verification/edgeAcceleratorTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
set -u

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module edgeAcceleratorTb -f vlog.f -o simv; then
    echo "Verilator build failed."
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log

if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus."
fi

if grep -qx "Test passed" sim.log; then
    echo "Simulation result: PASS"
    exit 0
fi

echo "Simulation result: FAIL"
exit 1
